/* source/remote_consts.svh */
`ifndef REMOTE_CONSTS_SVH
`define REMOTE_CONSTS_SVH

// core byte address
`define EVA_WIDTH 16

// data word, also the payload width
`define DATA_WIDTH 32

// one bank per x coordinate
`define NUM_BANKS 4
`define X_WIDTH 2

// word address inside one bank
`define EPA_WIDTH 8

// destination register tag
`define REG_ID_WIDTH 5

`endif

/* source/remote_pkg.sv */
`include "remote_consts.svh"

package remote_pkg;

  typedef enum logic [1:0] {
    e_remote_load    = 2'b00,
    e_remote_store   = 2'b01,
    e_remote_amo_add = 2'b10
  } remote_op_e;

  // which core port a response goes to
  typedef enum logic [1:0] {
    e_return_int_wb   = 2'b00,
    e_return_float_wb = 2'b01,
    e_return_ifetch   = 2'b10
  } return_type_e;

  typedef struct packed {
    logic is_float;
    logic is_ifetch;
  } load_info_s;

  // load view of the payload, info in the low bits
  typedef struct packed {
    logic [`DATA_WIDTH-$bits(load_info_s)-1:0] reserved;
    load_info_s info;
  } load_payload_s;

  // store and amo carry a data word, a load carries its info
  typedef union packed {
    logic [`DATA_WIDTH-1:0] data;
    load_payload_s load;
  } remote_payload_u;

endpackage

/* source/eva_to_npa.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module eva_to_npa (
  input  logic [`EVA_WIDTH-1:0] eva_i
  , input  logic                  dram_enable_i
  , input  logic [`X_WIDTH-1:0]   tgo_x_i
  , output logic [`X_WIDTH-1:0]   x_o
  , output logic [`EPA_WIDTH-1:0] epa_o
  , output logic                  invalid_o
);

  logic [1:0]          region;
  logic [`X_WIDTH:0]   tg_x_sum;

  assign region = eva_i[`EVA_WIDTH-1 -: 2];

  // tile-group offset, one bit wider to catch overflow
  assign tg_x_sum = {1'b0, tgo_x_i} + (`X_WIDTH+1)'(eva_i[13:12]);

  always_comb begin
    x_o       = '0;
    epa_o     = '0;
    invalid_o = 1'b1;
    case (region)
      // striped over all banks by word
      2'b10: begin
        x_o       = eva_i[2 +: `X_WIDTH];
        epa_o     = eva_i[4 +: `EPA_WIDTH];
        invalid_o = ~dram_enable_i | (eva_i[13:12] != 2'b00);
      end
      // tile-group, one bank per window
      2'b01: begin
        x_o       = tg_x_sum[`X_WIDTH-1:0];
        epa_o     = eva_i[2 +: `EPA_WIDTH];
        invalid_o = (tg_x_sum >= `NUM_BANKS) | (eva_i[11:10] != 2'b00);
      end
      default: begin
        invalid_o = 1'b1;
      end
    endcase
  end

endmodule

/* source/network_tx.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module network_tx (
  input  logic clk_i
  , input  logic reset_i
  , input  logic dram_enable_i
  , input  logic [`X_WIDTH-1:0] tgo_x_i

  // core request side
  , input  logic                          req_v_i
  , output logic                          req_ready_o
  , input  logic [`EVA_WIDTH-1:0]         req_addr_i
  , input  logic [`DATA_WIDTH-1:0]        req_data_i
  , input  logic [`DATA_WIDTH/8-1:0]      req_mask_i
  , input  remote_pkg::remote_op_e        req_op_i
  , input  logic [`REG_ID_WIDTH-1:0]      req_reg_id_i
  , input  remote_pkg::load_info_s        req_load_info_i
  , output logic                          invalid_eva_o

  // outgoing packet
  , output logic                          pkt_v_o
  , input  logic                          pkt_ready_i
  , output logic [`X_WIDTH-1:0]           pkt_x_o
  , output logic [`EPA_WIDTH-1:0]         pkt_epa_o
  , output remote_pkg::remote_op_e        pkt_op_o
  , output logic [`DATA_WIDTH/8-1:0]      pkt_mask_o
  , output logic [`REG_ID_WIDTH-1:0]      pkt_reg_id_o
  , output remote_pkg::remote_payload_u   pkt_payload_o

  // merged bank responses
  , input  logic                          rv_i
  , output logic                          rready_o
  , input  logic [`DATA_WIDTH-1:0]        rdata_i
  , input  logic [`REG_ID_WIDTH-1:0]      rreg_id_i
  , input  remote_pkg::return_type_e      rtype_i

  // core response classes
  , output logic                          int_resp_v_o
  , input  logic                          int_resp_ready_i
  , output logic [`DATA_WIDTH-1:0]        int_resp_data_o
  , output logic [`REG_ID_WIDTH-1:0]      int_resp_rd_o
  , output logic                          float_resp_v_o
  , input  logic                          float_resp_ready_i
  , output logic [`DATA_WIDTH-1:0]        float_resp_data_o
  , output logic [`REG_ID_WIDTH-1:0]      float_resp_rd_o
  , output logic                          ifetch_v_o
  , input  logic                          ifetch_ready_i
  , output logic [`DATA_WIDTH-1:0]        ifetch_instr_o
);

  logic invalid_addr;

  eva_to_npa eva2npa (
    .eva_i         (req_addr_i)
    , .dram_enable_i (dram_enable_i)
    , .tgo_x_i       (tgo_x_i)
    , .x_o           (pkt_x_o)
    , .epa_o         (pkt_epa_o)
    , .invalid_o     (invalid_addr)
  );

  // payload view depends on the op
  always_comb begin
    if (req_op_i == remote_pkg::e_remote_load) begin
      pkt_payload_o.load.reserved = '0;
      pkt_payload_o.load.info     = req_load_info_i;
    end else begin
      pkt_payload_o.data = req_data_i;
    end
  end

  assign pkt_op_o     = req_op_i;
  assign pkt_mask_o   = req_mask_i;
  assign pkt_reg_id_o = req_reg_id_i;

  // bad address is swallowed without a packet
  assign pkt_v_o       = req_v_i & ~invalid_addr;
  assign invalid_eva_o = req_v_i & invalid_addr;
  assign req_ready_o   = invalid_addr | pkt_ready_i;

  assign int_resp_data_o   = rdata_i;
  assign int_resp_rd_o     = rreg_id_i;
  assign float_resp_data_o = rdata_i;
  assign float_resp_rd_o   = rreg_id_i;
  assign ifetch_instr_o    = rdata_i;

  always_comb begin
    int_resp_v_o   = 1'b0;
    float_resp_v_o = 1'b0;
    ifetch_v_o     = 1'b0;
    case (rtype_i)
      remote_pkg::e_return_ifetch: begin
        ifetch_v_o = rv_i;
        rready_o   = ifetch_ready_i;
      end
      remote_pkg::e_return_float_wb: begin
        float_resp_v_o = rv_i;
        rready_o       = float_resp_ready_i;
      end
      default: begin
        int_resp_v_o = rv_i;
        rready_o     = int_resp_ready_i;
      end
    endcase
  end

  // a stalled return keeps the class outputs still
  ret_hold_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rv_i && !rready_o |=> rv_i && $stable(rdata_i) && $stable(rreg_id_i)
                          && $stable(rtype_i)
  ) else $error("return changed while stalled");

endmodule

/* source/packet_router.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module packet_router (
  input  logic                    pkt_v_i
  , output logic                    pkt_ready_o
  , input  logic [`X_WIDTH-1:0]     pkt_x_i
  , output logic [`NUM_BANKS-1:0]   bank_v_o
  , input  logic [`NUM_BANKS-1:0]   bank_ready_i
);

  // x coordinate to per-bank valid
  always_comb begin
    for (int i = 0; i < `NUM_BANKS; i++) begin
      bank_v_o[i] = pkt_v_i & (pkt_x_i == `X_WIDTH'(i));
    end
  end

  // ready comes back from the addressed bank only
  assign pkt_ready_o = bank_ready_i[pkt_x_i];

endmodule

/* source/epa_bank.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module epa_bank (
  input  logic clk_i
  , input  logic reset_i

  , input  logic                          in_v_i
  , output logic                          in_ready_o
  , input  logic [`EPA_WIDTH-1:0]         in_epa_i
  , input  remote_pkg::remote_op_e        in_op_i
  , input  logic [`DATA_WIDTH/8-1:0]      in_mask_i
  , input  logic [`REG_ID_WIDTH-1:0]      in_reg_id_i
  , input  remote_pkg::remote_payload_u   in_payload_i

  , output logic                          out_v_o
  , input  logic                          out_ready_i
  , output logic [`DATA_WIDTH-1:0]        out_data_o
  , output logic [`REG_ID_WIDTH-1:0]      out_reg_id_o
  , output remote_pkg::return_type_e      out_type_o
);

  logic [`DATA_WIDTH-1:0] mem_q [0:(1<<`EPA_WIDTH)-1];

  logic                   sweep_active_q;
  logic [`EPA_WIDTH-1:0]  sweep_addr_q;
  logic                   accept;
  logic                   needs_resp;
  logic [`DATA_WIDTH-1:0] old_word;
  logic [`DATA_WIDTH-1:0] src_word;
  logic [`DATA_WIDTH-1:0] new_word;
  remote_pkg::return_type_e resp_type;

  // free while the response slot is empty or draining
  assign in_ready_o = ~sweep_active_q & (~out_v_o | out_ready_i);
  assign accept     = in_v_i & in_ready_o;
  assign needs_resp = (in_op_i != remote_pkg::e_remote_store);

  assign old_word = mem_q[in_epa_i];
  assign src_word = (in_op_i == remote_pkg::e_remote_amo_add)
                  ? old_word + in_payload_i.data
                  : in_payload_i.data;

  // byte merge for store and amo
  always_comb begin
    for (int b = 0; b < `DATA_WIDTH/8; b++) begin
      new_word[8*b +: 8] = in_mask_i[b] ? src_word[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  always_comb begin
    if (in_op_i == remote_pkg::e_remote_amo_add) begin
      resp_type = remote_pkg::e_return_int_wb;
    end else if (in_payload_i.load.info.is_ifetch) begin
      resp_type = remote_pkg::e_return_ifetch;
    end else if (in_payload_i.load.info.is_float) begin
      resp_type = remote_pkg::e_return_float_wb;
    end else begin
      resp_type = remote_pkg::e_return_int_wb;
    end
  end

  // zero sweep after reset, one word per cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sweep_active_q <= 1'b1;
      sweep_addr_q   <= '0;
    end else if (sweep_active_q) begin
      sweep_addr_q <= sweep_addr_q + 1'b1;
      if (sweep_addr_q == '1) begin
        sweep_active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sweep_active_q) begin
      mem_q[sweep_addr_q] <= '0;
    end else if (accept && in_op_i != remote_pkg::e_remote_load) begin
      mem_q[in_epa_i] <= new_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_v_o <= 1'b0;
    end else if (accept && needs_resp) begin
      out_v_o <= 1'b1;
    end else if (out_ready_i) begin
      out_v_o <= 1'b0;
    end
  end

  // amo returns the word before the add
  always_ff @(posedge clk_i) begin
    if (accept && needs_resp) begin
      out_data_o   <= old_word;
      out_reg_id_o <= in_reg_id_i;
      out_type_o   <= resp_type;
    end
  end

  resp_hold_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    out_v_o && !out_ready_i |=> out_v_o && $stable(out_data_o) && $stable(out_reg_id_o)
  ) else $error("response register overwritten before it was taken");

endmodule

/* source/return_arbiter.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module return_arbiter (
  input  logic clk_i
  , input  logic reset_i

  , input  logic [`NUM_BANKS-1:0]     ret_v_i
  , output logic [`NUM_BANKS-1:0]     ret_ready_o
  , input  logic [`DATA_WIDTH-1:0]    ret_data_i   [`NUM_BANKS]
  , input  logic [`REG_ID_WIDTH-1:0]  ret_reg_id_i [`NUM_BANKS]
  , input  remote_pkg::return_type_e  ret_type_i   [`NUM_BANKS]

  , output logic                      rv_o
  , input  logic                      rready_i
  , output logic [`DATA_WIDTH-1:0]    rdata_o
  , output logic [`REG_ID_WIDTH-1:0]  rreg_id_o
  , output remote_pkg::return_type_e  rtype_o
);

  logic [`X_WIDTH-1:0] ptr_q;
  logic [`X_WIDTH-1:0] grant_idx;
  logic                grant_found;

  function automatic logic [`X_WIDTH-1:0] wrap_idx(input logic [`X_WIDTH-1:0] base,
                                                   input int offs);
    int sum;
    sum = int'(base) + offs;
    if (sum >= `NUM_BANKS) begin
      sum = sum - `NUM_BANKS;
    end
    return `X_WIDTH'(sum);
  endfunction

  // first valid bank at or after the pointer
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < `NUM_BANKS; k++) begin
      if (!grant_found && ret_v_i[wrap_idx(ptr_q, k)]) begin
        grant_found = 1'b1;
        grant_idx   = wrap_idx(ptr_q, k);
      end
    end
  end

  assign rv_o      = grant_found;
  assign rdata_o   = ret_data_i[grant_idx];
  assign rreg_id_o = ret_reg_id_i[grant_idx];
  assign rtype_o   = ret_type_i[grant_idx];

  always_comb begin
    for (int i = 0; i < `NUM_BANKS; i++) begin
      ret_ready_o[i] = grant_found & rready_i & (grant_idx == `X_WIDTH'(i));
    end
  end

  // a stalled grant pins the pointer so the output stays put
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (rv_o && rready_i) begin
      ptr_q <= wrap_idx(grant_idx, 1);
    end else if (rv_o) begin
      ptr_q <= grant_idx;
    end
  end

endmodule

/* source/remote_mem_top.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module remote_mem_top (
  input  logic clk_i
  , input  logic reset_i
  , input  logic dram_enable_i
  , input  logic [`X_WIDTH-1:0] tgo_x_i

  , input  logic                          req_v_i
  , output logic                          req_ready_o
  , input  logic [`EVA_WIDTH-1:0]         req_addr_i
  , input  logic [`DATA_WIDTH-1:0]        req_data_i
  , input  logic [`DATA_WIDTH/8-1:0]      req_mask_i
  , input  remote_pkg::remote_op_e        req_op_i
  , input  logic [`REG_ID_WIDTH-1:0]      req_reg_id_i
  , input  remote_pkg::load_info_s        req_load_info_i
  , output logic                          invalid_eva_o

  , output logic                          int_resp_v_o
  , input  logic                          int_resp_ready_i
  , output logic [`DATA_WIDTH-1:0]        int_resp_data_o
  , output logic [`REG_ID_WIDTH-1:0]      int_resp_rd_o
  , output logic                          float_resp_v_o
  , input  logic                          float_resp_ready_i
  , output logic [`DATA_WIDTH-1:0]        float_resp_data_o
  , output logic [`REG_ID_WIDTH-1:0]      float_resp_rd_o
  , output logic                          ifetch_v_o
  , input  logic                          ifetch_ready_i
  , output logic [`DATA_WIDTH-1:0]        ifetch_instr_o
);

  // packet from network_tx
  logic                          pkt_v;
  logic                          pkt_ready;
  logic [`X_WIDTH-1:0]           pkt_x;
  logic [`EPA_WIDTH-1:0]         pkt_epa;
  remote_pkg::remote_op_e        pkt_op;
  logic [`DATA_WIDTH/8-1:0]      pkt_mask;
  logic [`REG_ID_WIDTH-1:0]      pkt_reg_id;
  remote_pkg::remote_payload_u   pkt_payload;

  logic [`NUM_BANKS-1:0]         bank_v;
  logic [`NUM_BANKS-1:0]         bank_ready;

  // bank responses
  logic [`NUM_BANKS-1:0]         ret_v;
  logic [`NUM_BANKS-1:0]         ret_ready;
  logic [`DATA_WIDTH-1:0]        ret_data   [`NUM_BANKS];
  logic [`REG_ID_WIDTH-1:0]      ret_reg_id [`NUM_BANKS];
  remote_pkg::return_type_e      ret_type   [`NUM_BANKS];

  // merged return
  logic                          rv;
  logic                          rready;
  logic [`DATA_WIDTH-1:0]        rdata;
  logic [`REG_ID_WIDTH-1:0]      rreg_id;
  remote_pkg::return_type_e      rtype;

  network_tx tx_i (
    .clk_i              (clk_i)
    , .reset_i            (reset_i)
    , .dram_enable_i      (dram_enable_i)
    , .tgo_x_i            (tgo_x_i)
    , .req_v_i            (req_v_i)
    , .req_ready_o        (req_ready_o)
    , .req_addr_i         (req_addr_i)
    , .req_data_i         (req_data_i)
    , .req_mask_i         (req_mask_i)
    , .req_op_i           (req_op_i)
    , .req_reg_id_i       (req_reg_id_i)
    , .req_load_info_i    (req_load_info_i)
    , .invalid_eva_o      (invalid_eva_o)
    , .pkt_v_o            (pkt_v)
    , .pkt_ready_i        (pkt_ready)
    , .pkt_x_o            (pkt_x)
    , .pkt_epa_o          (pkt_epa)
    , .pkt_op_o           (pkt_op)
    , .pkt_mask_o         (pkt_mask)
    , .pkt_reg_id_o       (pkt_reg_id)
    , .pkt_payload_o      (pkt_payload)
    , .rv_i               (rv)
    , .rready_o           (rready)
    , .rdata_i            (rdata)
    , .rreg_id_i          (rreg_id)
    , .rtype_i            (rtype)
    , .int_resp_v_o       (int_resp_v_o)
    , .int_resp_ready_i   (int_resp_ready_i)
    , .int_resp_data_o    (int_resp_data_o)
    , .int_resp_rd_o      (int_resp_rd_o)
    , .float_resp_v_o     (float_resp_v_o)
    , .float_resp_ready_i (float_resp_ready_i)
    , .float_resp_data_o  (float_resp_data_o)
    , .float_resp_rd_o    (float_resp_rd_o)
    , .ifetch_v_o         (ifetch_v_o)
    , .ifetch_ready_i     (ifetch_ready_i)
    , .ifetch_instr_o     (ifetch_instr_o)
  );

  packet_router router_i (
    .pkt_v_i        (pkt_v)
    , .pkt_ready_o    (pkt_ready)
    , .pkt_x_i        (pkt_x)
    , .bank_v_o       (bank_v)
    , .bank_ready_i   (bank_ready)
  );

  // packet fields go to every bank, only the valid is steered
  for (genvar i = 0; i < `NUM_BANKS; i++) begin : bank_g
    epa_bank bank_i (
      .clk_i          (clk_i)
      , .reset_i        (reset_i)
      , .in_v_i         (bank_v[i])
      , .in_ready_o     (bank_ready[i])
      , .in_epa_i       (pkt_epa)
      , .in_op_i        (pkt_op)
      , .in_mask_i      (pkt_mask)
      , .in_reg_id_i    (pkt_reg_id)
      , .in_payload_i   (pkt_payload)
      , .out_v_o        (ret_v[i])
      , .out_ready_i    (ret_ready[i])
      , .out_data_o     (ret_data[i])
      , .out_reg_id_o   (ret_reg_id[i])
      , .out_type_o     (ret_type[i])
    );
  end

  return_arbiter arb_i (
    .clk_i          (clk_i)
    , .reset_i        (reset_i)
    , .ret_v_i        (ret_v)
    , .ret_ready_o    (ret_ready)
    , .ret_data_i     (ret_data)
    , .ret_reg_id_i   (ret_reg_id)
    , .ret_type_i     (ret_type)
    , .rv_o           (rv)
    , .rready_i       (rready)
    , .rdata_o        (rdata)
    , .rreg_id_o      (rreg_id)
    , .rtype_o        (rtype)
  );

endmodule

/* verification/remote_mem_tb.sv */
`timescale 1ns/1ps
`include "remote_consts.svh"

module remote_mem_tb;

  localparam int NUM_REQS      = 3000;
  localparam int REQ_TIMEOUT   = 2000;
  localparam int SWEEP_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT = 5000;
  localparam int NUM_TAGS      = 1 << `REG_ID_WIDTH;

  logic                         clk_i;
  logic                         reset_i;
  logic                         dram_enable_i;
  logic [`X_WIDTH-1:0]          tgo_x_i;
  logic                         req_v_i;
  logic                         req_ready_o;
  logic [`EVA_WIDTH-1:0]        req_addr_i;
  logic [`DATA_WIDTH-1:0]       req_data_i;
  logic [`DATA_WIDTH/8-1:0]     req_mask_i;
  remote_pkg::remote_op_e       req_op_i;
  logic [`REG_ID_WIDTH-1:0]     req_reg_id_i;
  remote_pkg::load_info_s       req_load_info_i;
  logic                         invalid_eva_o;
  logic                         int_resp_v_o;
  logic                         int_resp_ready_i;
  logic [`DATA_WIDTH-1:0]       int_resp_data_o;
  logic [`REG_ID_WIDTH-1:0]     int_resp_rd_o;
  logic                         float_resp_v_o;
  logic                         float_resp_ready_i;
  logic [`DATA_WIDTH-1:0]       float_resp_data_o;
  logic [`REG_ID_WIDTH-1:0]     float_resp_rd_o;
  logic                         ifetch_v_o;
  logic                         ifetch_ready_i;
  logic [`DATA_WIDTH-1:0]       ifetch_instr_o;

  // memory model with one word array per bank
  logic [`DATA_WIDTH-1:0]       mem_model [`NUM_BANKS][1<<`EPA_WIDTH];
  bit                           exp_busy  [NUM_TAGS];
  logic [`DATA_WIDTH-1:0]       exp_data  [NUM_TAGS];
  remote_pkg::return_type_e     exp_class [NUM_TAGS];
  // ifetch carries no tag so only one may be in flight
  bit                           ifetch_pending;
  logic [`REG_ID_WIDTH-1:0]     ifetch_tag;
  int                           outstanding;
  int                           errors;
  int                           responses;
  int                           n_invalid;
  bit                           timed_out;

  remote_mem_top dut_i (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  // address rules of the two regions
  function automatic void decode_eva(input logic [`EVA_WIDTH-1:0] eva, input logic dram,
                                     input logic [`X_WIDTH-1:0] tgo, output int x,
                                     output int epa, output bit bad);
    int tg;
    x   = 0;
    epa = 0;
    bad = 1'b1;
    if (eva[15:14] == 2'b10) begin
      x   = eva[3:2];
      epa = eva[11:4];
      bad = !dram || (eva[13:12] != 2'b00);
    end else if (eva[15:14] == 2'b01) begin
      tg  = int'(tgo) + int'(eva[13:12]);
      x   = tg;
      epa = eva[9:2];
      bad = (tg >= `NUM_BANKS) || (eva[11:10] != 2'b00);
    end
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] merge_bytes(input logic [3:0] mask,
                                                         input logic [`DATA_WIDTH-1:0] src,
                                                         input logic [`DATA_WIDTH-1:0] old);
    logic [`DATA_WIDTH-1:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = mask[b] ? src[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  task automatic expect_response(input logic [`REG_ID_WIDTH-1:0] tag,
                                 input logic [`DATA_WIDTH-1:0] data,
                                 input remote_pkg::return_type_e cls);
    exp_busy[tag]  = 1'b1;
    exp_data[tag]  = data;
    exp_class[tag] = cls;
    outstanding++;
    if (cls == remote_pkg::e_return_ifetch) begin
      ifetch_pending = 1'b1;
      ifetch_tag     = tag;
    end
  endtask

  task automatic retire_response(input remote_pkg::return_type_e cls,
                                 input logic [`REG_ID_WIDTH-1:0] tag,
                                 input logic [`DATA_WIDTH-1:0] data);
    if (!exp_busy[tag]) begin
      report_error($sformatf("unexpected response tag %0d data %h", tag, data));
    end else begin
      if (exp_class[tag] != cls) begin
        report_error($sformatf("tag %0d on class %0d, expected class %0d",
                               tag, cls, exp_class[tag]));
      end
      if (exp_data[tag] !== data) begin
        report_error($sformatf("tag %0d data %h, expected %h", tag, data, exp_data[tag]));
      end
      if (ifetch_pending && tag == ifetch_tag) begin
        ifetch_pending = 1'b0;
      end
      exp_busy[tag] = 1'b0;
      outstanding--;
      responses++;
    end
  endtask

  task automatic check_responses();
    int nvalid;
    nvalid = int'(int_resp_v_o) + int'(float_resp_v_o) + int'(ifetch_v_o);
    if (nvalid > 1) begin
      report_error("more than one response class valid");
    end
    if (int_resp_v_o && int_resp_ready_i) begin
      retire_response(remote_pkg::e_return_int_wb, int_resp_rd_o, int_resp_data_o);
    end
    if (float_resp_v_o && float_resp_ready_i) begin
      retire_response(remote_pkg::e_return_float_wb, float_resp_rd_o, float_resp_data_o);
    end
    if (ifetch_v_o && ifetch_ready_i) begin
      if (!ifetch_pending) begin
        report_error($sformatf("unexpected ifetch response %h", ifetch_instr_o));
      end else begin
        retire_response(remote_pkg::e_return_ifetch, ifetch_tag, ifetch_instr_o);
      end
    end
  endtask

  // model update in acceptance order
  task automatic accept_request();
    int x;
    int epa;
    bit bad;
    logic [`DATA_WIDTH-1:0] old_w;
    remote_pkg::return_type_e cls;
    decode_eva(req_addr_i, dram_enable_i, tgo_x_i, x, epa, bad);
    if (invalid_eva_o !== bad) begin
      report_error($sformatf("invalid_eva_o %b for eva %h, expected %b",
                             invalid_eva_o, req_addr_i, bad));
    end
    if (bad) begin
      n_invalid++;
    end else begin
      old_w = mem_model[x][epa];
      case (req_op_i)
        remote_pkg::e_remote_store: begin
          mem_model[x][epa] = merge_bytes(req_mask_i, req_data_i, old_w);
        end
        remote_pkg::e_remote_amo_add: begin
          mem_model[x][epa] = merge_bytes(req_mask_i, old_w + req_data_i, old_w);
          expect_response(req_reg_id_i, old_w, remote_pkg::e_return_int_wb);
        end
        default: begin
          if (req_load_info_i.is_ifetch) begin
            cls = remote_pkg::e_return_ifetch;
          end else if (req_load_info_i.is_float) begin
            cls = remote_pkg::e_return_float_wb;
          end else begin
            cls = remote_pkg::e_return_int_wb;
          end
          expect_response(req_reg_id_i, old_w, cls);
        end
      endcase
    end
  endtask

  task automatic find_free_tag(output bit found, output logic [`REG_ID_WIDTH-1:0] tag);
    int start;
    found = 1'b0;
    tag   = '0;
    start = $urandom % NUM_TAGS;
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (!found && !exp_busy[(start + i) % NUM_TAGS]) begin
        found = 1'b1;
        tag   = `REG_ID_WIDTH'((start + i) % NUM_TAGS);
      end
    end
  endtask

  task automatic issue_request();
    int kind;
    int op_sel;
    bit found;
    logic [`EPA_WIDTH-1:0] epa;
    logic [`X_WIDTH-1:0] x;
    logic [`REG_ID_WIDTH-1:0] tag;
    remote_pkg::load_info_s info;
    remote_pkg::remote_op_e op;
    kind = $urandom % 10;
    // few words per bank so accesses collide
    epa  = `EPA_WIDTH'($urandom % 8);
    x    = `X_WIDTH'($urandom);
    if (kind < 5) begin
      req_addr_i <= {2'b10, 2'b00, epa, x, 2'($urandom)};
    end else if (kind < 9) begin
      req_addr_i <= {2'b01, 2'($urandom), 2'b00, epa, 2'b00};
    end else begin
      req_addr_i <= 16'($urandom);
    end
    dram_enable_i <= ($urandom % 10) != 0;
    tgo_x_i       <= `X_WIDTH'($urandom);
    op_sel = $urandom % 20;
    info   = remote_pkg::load_info_s'(2'($urandom));
    find_free_tag(found, tag);
    if (op_sel < 8 || !found) begin
      op  = remote_pkg::e_remote_store;
      tag = `REG_ID_WIDTH'($urandom);
    end else if (op_sel < 11) begin
      op = remote_pkg::e_remote_amo_add;
    end else begin
      op = remote_pkg::e_remote_load;
    end
    if (ifetch_pending) begin
      info.is_ifetch = 1'b0;
    end
    req_v_i         <= 1'b1;
    req_data_i      <= $urandom;
    req_mask_i      <= 4'($urandom);
    req_op_i        <= op;
    req_reg_id_i    <= tag;
    req_load_info_i <= info;
  endtask

  task automatic drive_readies();
    int_resp_ready_i   <= ($urandom % 4) != 0;
    float_resp_ready_i <= ($urandom % 4) != 0;
    ifetch_ready_i     <= ($urandom % 4) != 0;
  endtask

  initial begin
    int wait_cnt;
    int issued;
    bit pending;
    clk_i              = 1'b0;
    reset_i            = 1'b1;
    dram_enable_i      = 1'b1;
    tgo_x_i            = '0;
    req_v_i            = 1'b0;
    req_addr_i         = 16'h8000;
    req_data_i         = '0;
    req_mask_i         = '0;
    req_op_i           = remote_pkg::e_remote_load;
    req_reg_id_i       = '0;
    req_load_info_i    = '0;
    int_resp_ready_i   = 1'b0;
    float_resp_ready_i = 1'b0;
    ifetch_ready_i     = 1'b0;
    void'($urandom(32'h78d7_ef73));
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int a = 0; a < (1 << `EPA_WIDTH); a++) begin
        mem_model[b][a] = '0;
      end
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      exp_busy[t] = 1'b0;
    end
    ifetch_pending = 1'b0;
    outstanding    = 0;
    errors         = 0;
    responses      = 0;
    n_invalid      = 0;
    timed_out      = 1'b0;

    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // banks clear their memory before taking requests
    wait_cnt = 0;
    while (!req_ready_o && !timed_out) begin
      @(posedge clk_i);
      if (int_resp_v_o || float_resp_v_o || ifetch_v_o) begin
        report_error("response valid during the bank sweep");
      end
      wait_cnt++;
      if (wait_cnt > SWEEP_TIMEOUT) begin
        $display("timeout: request port never became ready after reset");
        timed_out = 1'b1;
      end
    end

    issued   = 0;
    pending  = 1'b0;
    wait_cnt = 0;
    while ((issued < NUM_REQS || pending) && !timed_out) begin
      @(posedge clk_i);
      check_responses();
      if (req_v_i && req_ready_o) begin
        accept_request();
        pending = 1'b0;
      end
      drive_readies();
      if (pending) begin
        wait_cnt++;
        if (wait_cnt > REQ_TIMEOUT) begin
          $display("timeout: request %0d was never accepted", issued);
          timed_out = 1'b1;
        end
      end else if (issued < NUM_REQS && ($urandom % 8) != 0) begin
        issue_request();
        pending  = 1'b1;
        wait_cnt = 0;
        issued++;
      end else begin
        req_v_i <= 1'b0;
      end
    end

    wait_cnt = 0;
    while (outstanding > 0 && !timed_out) begin
      @(posedge clk_i);
      check_responses();
      drive_readies();
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) begin
        $display("timeout: %0d responses never arrived", outstanding);
        timed_out = 1'b1;
      end
    end

    // watch for stray responses with all readies high
    int_resp_ready_i   <= 1'b1;
    float_resp_ready_i <= 1'b1;
    ifetch_ready_i     <= 1'b1;
    repeat (20) begin
      @(posedge clk_i);
      check_responses();
    end

    $display("responses %0d, invalid %0d, errors %0d, timeouts %0d",
             responses, n_invalid, errors, int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/remote_pkg.sv
source/eva_to_npa.sv
source/network_tx.sv
source/packet_router.sv
source/epa_bank.sv
source/return_arbiter.sv
source/remote_mem_top.sv
verification/remote_mem_tb.sv

/* Bender.yml */
package:
  name: remote_mem

export_include_dirs:
  - source

sources:
  - files:
      - source/remote_pkg.sv
      - source/eva_to_npa.sv
      - source/network_tx.sv
      - source/packet_router.sv
      - source/epa_bank.sv
      - source/return_arbiter.sv
      - source/remote_mem_top.sv
  - target: test
    files:
      - verification/remote_mem_tb.sv
